//--- verilog/pe_pkg.sv
/* pe package
   widths, depths and the packed beats shared by the processing element */
`default_nettype none

package pe_pkg;

    // =========================================================================
    // sizes
    // =========================================================================
    localparam int PIX_W       = 16;  // pixel and weight width
    localparam int PSUM_W      = 32;  // partial sum width
    localparam int PAD_DEPTH   = 12;  // if_pad entries and initial pixel credits
    localparam int PAD_AW      = 4;
    localparam int WPAD_DEPTH  = 8;   // max filter length
    localparam int WPAD_AW     = 3;
    localparam int OUT_CREDITS = 4;   // psum credits after reset
    localparam int LEN_W       = 8;
    localparam int CRED_W      = 3;   // holds 0..OUT_CREDITS

    // =========================================================================
    // beats and commands
    // =========================================================================
    typedef struct packed {
        logic [WPAD_AW:0] filt_len;  // 1..8
        logic [LEN_W-1:0] out_len;   // 1..255
    } pe_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic signed [PIX_W-1:0] pix;
    } pix_beat_t;

    typedef struct packed {
        logic                    valid;
        logic signed [PIX_W-1:0] wgt;
    } wgt_beat_t;

    typedef struct packed {
        logic                     valid;
        logic signed [PSUM_W-1:0] sum;
    } psum_beat_t;

    // one read per cycle from the window walker
    typedef struct packed {
        logic               en;
        logic [WPAD_AW-1:0] off;   // offset from window base
        logic               last;  // final term of the window
    } pad_rd_t;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic                    zero;
        logic signed [PIX_W-1:0] pix;
        logic signed [PIX_W-1:0] wgt;
    } term_t;

endpackage

`default_nettype wire

//--- verilog/if_pad.sv
/* input feature pad
   circular pixel file with zero flags, sliding read window and credit return */
`timescale 1ns/10ps
`default_nettype none

module if_pad
    import pe_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rstn,
    input  pix_beat_t         pix_in,
    input  pad_rd_t           rd,
    input  logic              pop,
    input  logic              flush,
    output logic [PAD_AW-1:0] fill,
    output logic              zero_flag,
    output logic [PIX_W-1:0]  pix_q,
    output logic              zero_q,
    output logic              pix_credit
);

    logic [PIX_W-1:0]     mem [PAD_DEPTH];
    logic [PAD_DEPTH-1:0] zflag;  // one zero bit per entry
    logic [PAD_AW-1:0]    wr_ptr;
    logic [PAD_AW-1:0]    base;   // window base
    logic [PAD_AW-1:0]    wr_addr;
    logic [PAD_AW:0]      rd_sum;
    logic [PAD_AW-1:0]    rd_addr;

    // wraps at PAD_DEPTH rather than a power of two
    function automatic logic [PAD_AW-1:0] ptr_inc(input logic [PAD_AW-1:0] p);
        if (p == PAD_AW'(PAD_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // =========================================================================
    // addressing
    // =========================================================================
    assign wr_addr = flush ? '0 : wr_ptr;  // beat arriving with flush lands at 0
    assign rd_sum  = {1'b0, base} + (PAD_AW+1)'(rd.off);

    always_comb begin
        if (rd_sum >= (PAD_AW+1)'(PAD_DEPTH)) begin
            rd_addr = PAD_AW'(rd_sum - (PAD_AW+1)'(PAD_DEPTH));
        end else begin
            rd_addr = rd_sum[PAD_AW-1:0];
        end
    end

    assign zero_flag = zflag[rd_addr];  // to w_pad in the same cycle

    // =========================================================================
    // storage
    // =========================================================================
    always_ff @(posedge i_clk) begin
        if (pix_in.valid) begin
            mem[wr_addr]   <= pix_in.pix;
            zflag[wr_addr] <= (pix_in.pix == '0);
        end
    end

    // registered read against the old base when pop is high
    always_ff @(posedge i_clk) begin
        if (rd.en) begin
            pix_q  <= mem[rd_addr];
            zero_q <= zflag[rd_addr];
        end
    end

    // =========================================================================
    // pointers, fill and credits
    // =========================================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr     <= '0;
            base       <= '0;
            fill       <= '0;
            pix_credit <= 1'b0;
        end else begin
            pix_credit <= pop;  // one credit per freed entry
            if (flush) begin
                // pad is empty after the drain
                base   <= '0;
                wr_ptr <= pix_in.valid ? PAD_AW'(1) : '0;
                fill   <= pix_in.valid ? PAD_AW'(1) : '0;
            end else begin
                if (pix_in.valid) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (pop) begin
                    base <= ptr_inc(base);
                end
                case ({pix_in.valid, pop})
                    2'b10:   fill <= fill + 1'b1;
                    2'b01:   fill <= fill - 1'b1;
                    default: fill <= fill;  // both or neither
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/w_pad.sv
/* weight pad
   filter row register file, read skipped when the paired pixel is zero */
`timescale 1ns/10ps
`default_nettype none

module w_pad
    import pe_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rstn,
    input  wgt_beat_t        w_in,
    input  logic             busy,
    input  logic             done,
    input  pad_rd_t          rd,
    input  logic             zero_flag,
    output logic [PIX_W-1:0] wgt_q,
    output logic             term_vld,
    output logic             term_last
);

    logic [PIX_W-1:0]   mem [WPAD_DEPTH];
    logic [WPAD_AW-1:0] wr_ptr;
    logic               wr_en;

    assign wr_en = w_in.valid && !busy;  // load only while idle

    // =========================================================================
    // load
    // =========================================================================
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= w_in.wgt;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr <= '0;
        end else if (done) begin
            wr_ptr <= '0;  // next row starts at index 0
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // =========================================================================
    // read
    // =========================================================================
    // zero pixel leaves the old weight in place
    always_ff @(posedge i_clk) begin
        if (rd.en && !zero_flag) begin
            wgt_q <= mem[rd.off];
        end
    end

    // tag travels with the pixel read
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            term_vld  <= 1'b0;
            term_last <= 1'b0;
        end else begin
            term_vld  <= rd.en;
            term_last <= rd.en && rd.last;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pe_ctrl.sv
/* pe controller
   window walk over the pads, psum credit gating, drain and flush */
`timescale 1ns/10ps
`default_nettype none

module pe_ctrl
    import pe_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rstn,
    input  logic              start,
    input  pe_cfg_t           cfg,
    input  logic [PAD_AW-1:0] fill,
    input  logic              psum_credit,
    output pad_rd_t           rd,
    output logic              pop,
    output logic              busy,
    output logic              done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_WALK,
        S_DRAIN,
        S_FLUSH
    } state_t;

    state_t             state;
    pe_cfg_t            cfg_q;
    logic [WPAD_AW-1:0] off_cnt;     // offset in WALK, cycle count in DRAIN
    logic [LEN_W-1:0]   out_idx;
    logic [CRED_W-1:0]  credit_cnt;
    logic [WPAD_AW:0]   drain_last;
    logic               off_last;
    logic               last_win;
    logic               rsv;
    logic               can_issue;
    logic               can_chain;
    logic               drain_pop;
    logic               drain_end;

    // =========================================================================
    // decode
    // =========================================================================
    assign off_last  = ({1'b0, off_cnt} == cfg_q.filt_len - 1'b1);
    assign last_win  = (out_idx == cfg_q.out_len - 1'b1);
    assign rsv       = (state == S_WALK) && (off_cnt == '0);  // first read of a window
    assign can_issue = (credit_cnt != '0) && (fill >= cfg_q.filt_len);

    // pop lands this cycle, so one more entry than a window is needed
    assign can_chain = (rsv ? (credit_cnt > CRED_W'(1)) : (credit_cnt != '0))
                       && (fill > cfg_q.filt_len);

    // drain covers filt_len-1 pops, and at least two cycles for the mac tail
    assign drain_last = (cfg_q.filt_len > (WPAD_AW+1)'(3)) ? cfg_q.filt_len - 2'd2
                                                          : (WPAD_AW+1)'(1);
    assign drain_pop  = ({1'b0, off_cnt} < cfg_q.filt_len - 1'b1);
    assign drain_end  = ({1'b0, off_cnt} == drain_last);

    assign rd   = '{en: (state == S_WALK), off: off_cnt, last: (state == S_WALK) && off_last};
    assign pop  = ((state == S_WALK) && off_last) || ((state == S_DRAIN) && drain_pop);
    assign busy = (state != S_IDLE);
    assign done = (state == S_FLUSH);

    // =========================================================================
    // psum credits
    // =========================================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            credit_cnt <= CRED_W'(OUT_CREDITS);
        end else begin
            case ({rsv, psum_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // =========================================================================
    // fsm
    // =========================================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state   <= S_IDLE;
            cfg_q   <= '0;
            off_cnt <= '0;
            out_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        cfg_q   <= cfg;
                        out_idx <= '0;
                        state   <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (can_issue) begin
                        state <= S_WALK;
                    end
                end
                S_WALK: begin
                    if (off_last) begin
                        off_cnt <= '0;
                        out_idx <= out_idx + 1'b1;
                        if (last_win) begin
                            state <= S_DRAIN;
                        end else if (!can_chain) begin
                            state <= S_WAIT;  // stall for pixels or credit
                        end
                    end else begin
                        off_cnt <= off_cnt + 1'b1;
                    end
                end
                S_DRAIN: begin
                    off_cnt <= off_cnt + 1'b1;
                    if (drain_end) begin
                        state <= S_FLUSH;
                    end
                end
                default: begin  // S_FLUSH lasts one cycle
                    off_cnt <= '0;
                    state   <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/mac_unit.sv
/* mac unit
   signed multiply-accumulate with zero skip, one psum per window */
`timescale 1ns/10ps
`default_nettype none

module mac_unit
    import pe_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rstn,
    input  term_t      term,
    output psum_beat_t psum_out
);

    logic signed [PSUM_W-1:0] acc;
    logic signed [PSUM_W-1:0] prod;
    logic signed [PSUM_W-1:0] acc_nxt;
    logic signed [PSUM_W-1:0] out_sum;
    logic                     out_vld;

    // full 16x16 product fits in 32 bits
    assign prod    = $signed(term.pix) * $signed(term.wgt);
    assign acc_nxt = term.zero ? acc : acc + prod;  // zero pixel adds nothing

    // =========================================================================
    // accumulate
    // =========================================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            acc     <= '0;
            out_vld <= 1'b0;
        end else begin
            out_vld <= term.valid && term.last;
            if (term.valid) begin
                acc <= term.last ? '0 : acc_nxt;  // fresh start per window
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (term.valid && term.last) begin
            out_sum <= acc_nxt;
        end
    end

    assign psum_out = '{valid: out_vld, sum: out_sum};

endmodule

`default_nettype wire

//--- verilog/pe_top.sv
/* processing element top
   pads, window controller and mac joined into one row-stationary pe */
`timescale 1ns/10ps
`default_nettype none

module pe_top
    import pe_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rstn,
    input  pe_cfg_t    cfg,
    input  logic       start,
    input  wgt_beat_t  w_in,
    input  pix_beat_t  pix_in,
    output logic       pix_credit,
    output psum_beat_t psum_out,
    input  logic       psum_credit,
    output logic       busy,
    output logic       done
);

    pad_rd_t           rd;
    logic              pop;
    logic [PAD_AW-1:0] fill;
    logic              zero_flag;
    logic [PIX_W-1:0]  pix_q;
    logic              zero_q;
    logic [PIX_W-1:0]  wgt_q;
    logic              term_vld;
    logic              term_last;
    term_t             term;

    pe_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .start       (start),
        .cfg         (cfg),
        .fill        (fill),
        .psum_credit (psum_credit),
        .rd          (rd),
        .pop         (pop),
        .busy        (busy),
        .done        (done)
    );

    if_pad u_if_pad (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .pix_in     (pix_in),
        .rd         (rd),
        .pop        (pop),
        .flush      (done),  // pointers back to 0 after drain
        .fill       (fill),
        .zero_flag  (zero_flag),
        .pix_q      (pix_q),
        .zero_q     (zero_q),
        .pix_credit (pix_credit)
    );

    w_pad u_w_pad (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .w_in      (w_in),
        .busy      (busy),
        .done      (done),
        .rd        (rd),
        .zero_flag (zero_flag),
        .wgt_q     (wgt_q),
        .term_vld  (term_vld),
        .term_last (term_last)
    );

    // pixel and weight meet here one cycle after the read
    assign term = '{valid: term_vld, last: term_last, zero: zero_q, pix: pix_q, wgt: wgt_q};

    mac_unit u_mac (
        .i_clk    (i_clk),
        .i_rstn   (i_rstn),
        .term     (term),
        .psum_out (psum_out)
    );

endmodule

`default_nettype wire

//--- tb/tb_pe.sv
/* pe testbench
   file driven convolution cases with credit paced pixels and delayed psum credits */
`timescale 1ns/10ps
`default_nettype none

module tb_pe
    import pe_pkg::*;
();

    logic       i_clk;
    logic       i_rstn;
    pe_cfg_t    cfg;
    logic       start;
    wgt_beat_t  w_in;
    pix_beat_t  pix_in;
    logic       pix_credit;
    psum_beat_t psum_out;
    logic       psum_credit;
    logic       busy;
    logic       done;

    // case data consumed front to back
    int         case_filt[$];
    int         case_out[$];
    int         wgt_all[$];
    int         pix_all[$];
    int         exp_all[$];

    int         fd;
    logic [7:0] lfsr;
    int         cyc;
    int         tmo_cnt;
    int         tmo_limit;
    int         credits;      // sender side pixel credits
    int         cur_pix[$];   // pixels of the running case not yet sent
    int         cur_out_len;
    int         case_psums;
    int         psum_total;
    int         cred_given;   // psum credits handed back so far
    int         due_q[$];     // cycle at which each psum credit goes back
    bit         run_active;
    bit         done_seen;

    pe_top u_dut (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .cfg         (cfg),
        .start       (start),
        .w_in        (w_in),
        .pix_in      (pix_in),
        .pix_credit  (pix_credit),
        .psum_out    (psum_out),
        .psum_credit (psum_credit),
        .busy        (busy),
        .done        (done)
    );

    always #20 i_clk = ~i_clk;

    // =========================================================================
    // helpers
    // =========================================================================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // fibonacci lfsr with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic check_psum(input psum_beat_t got, input psum_beat_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch psum_out got 0x%0h_%08h expected 0x%0h_%08h",
                                        got.valid, got.sum, exp.valid, exp.sum));
        end
    endtask

    task automatic check_credit_count(input string name, input logic [PAD_AW-1:0] got,
                                      input logic [PAD_AW-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // next decimal token, skipping # comments to end of line
    task automatic read_int(output int val, output bit ok);
        string tok;
        string rest;
        int    n;
        ok  = 1'b0;
        val = 0;
        n   = $fscanf(fd, "%s", tok);
        while (n == 1 && tok.substr(0, 0) == "#") begin
            n = $fgets(rest, fd);
            n = $fscanf(fd, "%s", tok);
        end
        if (n == 1) begin
            ok = ($sscanf(tok, "%d", val) == 1);
        end
    endtask

    task automatic read_field(output int val);
        bit ok;
        read_int(val, ok);
        if (!ok) begin
            stop_with_failure("case file ends inside a case or holds a bad number");
        end
    endtask

    task automatic load_cases();
        int filt;
        int outl;
        int v;
        int k;
        int work;
        bit ok;
        bit more;
        fd = $fopen("tb/pe_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open tb/pe_cases.txt");
        end
        work = 0;
        more = 1'b1;
        while (more) begin
            read_int(filt, ok);
            if (!ok || filt == 0) begin
                more = 1'b0;  // lone 0 ends the list
            end else begin
                read_field(outl);
                if (filt < 1 || filt > WPAD_DEPTH || outl < 1 || outl > 255) begin
                    stop_with_failure("case file gives a filter or output length out of range");
                end
                case_filt.push_back(filt);
                case_out.push_back(outl);
                for (k = 0; k < filt; k++) begin
                    read_field(v);
                    wgt_all.push_back(v);
                end
                for (k = 0; k < outl + filt - 1; k++) begin
                    read_field(v);
                    pix_all.push_back(v);
                end
                for (k = 0; k < outl; k++) begin
                    read_field(v);
                    exp_all.push_back(v);
                end
                work += outl + filt - 1 + outl * filt;
            end
        end
        $fclose(fd);
        if (case_filt.size() == 0) begin
            stop_with_failure("case file holds no cases");
        end
        tmo_limit = 8 * work + 200;
    endtask

    // =========================================================================
    // one clock of sampling and checking before credits and pixels are driven
    // =========================================================================
    task automatic tick();
        psum_beat_t exp_beat;
        pix_beat_t  pb;
        int         junk;
        @(posedge i_clk);
        cyc++;
        if (pix_credit) begin
            credits++;
            if (credits > PAD_DEPTH) begin
                stop_with_failure("pixel credit returned with no pixel outstanding");
            end
        end
        if (psum_out.valid) begin
            if (!run_active || case_psums >= cur_out_len || exp_all.size() == 0) begin
                stop_with_failure("psum beat with no window left to compute");
            end
            exp_beat.valid = 1'b1;
            exp_beat.sum   = PSUM_W'(exp_all.pop_front());
            check_psum(psum_out, exp_beat);
            case_psums++;
            psum_total++;
            if (psum_total > OUT_CREDITS + cred_given) begin
                stop_with_failure("more psums sent than psum credits given");
            end
            due_q.push_back(cyc + rand_bits(3));  // back after 0..7 cycles
        end
        if (done) begin
            if (!run_active) begin
                stop_with_failure("done pulsed while no case was running");
            end
            if (case_psums != cur_out_len) begin
                stop_with_failure($sformatf("done after %0d of %0d psums",
                                            case_psums, cur_out_len));
            end
            if (cur_pix.size() != 0) begin
                stop_with_failure("done before all pixels were sent");
            end
            check_credit_count("pix_credit", PAD_AW'(credits), PAD_AW'(PAD_DEPTH));
            run_active = 1'b0;
            done_seen  = 1'b1;
        end
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            junk = due_q.pop_front();
            cred_given++;
            psum_credit <= 1'b1;
        end else begin
            psum_credit <= 1'b0;
        end
        pb.valid = 1'b0;
        pb.pix   = '0;
        if (cur_pix.size() > 0 && credits > 0 && rand_bits(2) != 0) begin
            pb.valid = 1'b1;
            pb.pix   = PIX_W'(cur_pix.pop_front());
            credits--;
        end
        pix_in <= pb;
    endtask

    task automatic run_case(input int idx);
        int        filt;
        int        k;
        wgt_beat_t wb;
        pe_cfg_t   cb;
        filt        = case_filt.pop_front();
        cur_out_len = case_out.pop_front();
        $display("case %0d: filt_len %0d out_len %0d", idx, filt, cur_out_len);
        for (k = 0; k < filt; k++) begin
            wb.valid = 1'b1;
            wb.wgt   = PIX_W'(wgt_all.pop_front());
            w_in <= wb;
            tick();
        end
        w_in <= '0;
        cb.filt_len = (WPAD_AW+1)'(filt);
        cb.out_len  = LEN_W'(cur_out_len);
        cfg   <= cb;
        start <= 1'b1;
        for (k = 0; k < cur_out_len + filt - 1; k++) begin
            cur_pix.push_back(pix_all.pop_front());
        end
        case_psums = 0;
        done_seen  = 1'b0;
        run_active = 1'b1;
        tick();
        start <= 1'b0;
        while (!done_seen) begin
            tick();
        end
    endtask

    // =========================================================================
    // main sequence
    // =========================================================================
    initial begin
        int idx;
        int n_case;
        i_clk       = 1'b0;
        i_rstn      = 1'b0;
        cfg         = '0;
        start       = 1'b0;
        w_in        = '0;
        pix_in      = '0;
        psum_credit = 1'b0;
        lfsr        = 8'd35;
        cyc         = 0;
        tmo_cnt     = 0;
        tmo_limit   = 0;
        credits     = PAD_DEPTH;
        psum_total  = 0;
        cred_given  = 0;
        run_active  = 1'b0;
        load_cases();
        n_case = case_filt.size();
        repeat (16) @(posedge i_clk);
        i_rstn <= 1'b1;
        tick();
        if (busy !== 1'b0 || done !== 1'b0 || psum_out.valid !== 1'b0) begin
            stop_with_failure($sformatf("mismatch busy/done/psum_out.valid got 0x%0h expected 0x0",
                                        {busy, done, psum_out.valid}));
        end
        for (idx = 0; idx < n_case; idx++) begin
            run_case(idx);
        end
        while (due_q.size() > 0) begin
            tick();  // last psum credits go home
        end
        repeat (4) tick();
        $display("Test passed");
        $finish;
    end

    always @(posedge i_clk) begin
        if (tmo_limit > 0) begin
            tmo_cnt++;
            if (tmo_cnt > tmo_limit) begin
                stop_with_failure($sformatf("run did not finish within %0d cycles", tmo_limit));
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/pe_cases.txt
# per case: filt_len out_len weights, then out_len+filt_len-1 pixels,
# then out_len expected psums; all decimal, a lone 0 ends the list
3 4   1 2 3
1 2 3 4 5 6
14 20 26 32
1 5   -3
4 0 -7 100 2
-12 0 21 -300 -6
# eight taps, row longer than the pad
8 6   1 -1 2 -2 3 -3 4 -4
5 1 0 2 7 -3 6 1 2 0 4 -5 3
50 -40 41 -42 62 -55
# first window all zero
3 5   4 -1 2
0 0 0 9 0 -2 5
0 18 -9 32 12
2 3   32767 -32768
-32768 32767 -32768 1
-2147418112 2147418113 -1073741824
3 10  1 1 1
1 2 3 4 5 6 7 8 9 10 11 12
6 9 12 15 18 21 24 27 30 33
0

//--- tb.f
verilog/pe_pkg.sv
verilog/if_pad.sv
verilog/w_pad.sv
verilog/pe_ctrl.sv
verilog/mac_unit.sv
verilog/pe_top.sv
tb/tb_pe.sv

//--- Bender.yml
package:
  name: rs_pe

sources:
  - verilog/pe_pkg.sv
  - verilog/if_pad.sv
  - verilog/w_pad.sv
  - verilog/pe_ctrl.sv
  - verilog/mac_unit.sv
  - verilog/pe_top.sv
  - target: simulation
    files:
      - tb/tb_pe.sv
